/* Bender.yml */
package:
  name: front_end

sources:
  - rtl/front_end_pkg.sv
  - rtl/pc_generate.sv
  - rtl/ifetch.sv
  - rtl/iqueue.sv
  - rtl/decoder.sv
  - rtl/front_end.sv
  - target: test
    files:
      - testbench/front_end_properties.sv
      - testbench/tb_clock_gen.sv
      - testbench/tb_front_end.sv

/* project.f */
rtl/front_end_pkg.sv
rtl/pc_generate.sv
rtl/ifetch.sv
rtl/iqueue.sv
rtl/decoder.sv
rtl/front_end.sv
testbench/front_end_properties.sv
testbench/tb_clock_gen.sv
testbench/tb_front_end.sv

/* rtl/decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder (
	input  logic                         CLK,
	input  logic                         rst_n,
	input  logic                         flush,
	input  front_end_pkg::iq_bundle_t    iq_id,
	input  logic                         iq_id_valid,
	output logic                         iq_id_ready,
	input  logic                         instr_fifo_reject,
	output logic                         instr_fifo_push,
	output front_end_pkg::micro_instr_t  decode_micro
);
	import front_end_pkg::*;

	instr_u       ins;
	micro_instr_t next_micro;
	logic [63:0]  imm_i;
	logic [63:0]  imm_s;
	logic [63:0]  imm_b;
	logic [63:0]  imm_u;
	logic [63:0]  imm_j;
	logic         take;
	logic         funct7_ok; // Only 0000000 and 0100000 are defined

	assign ins         = iq_id.fb.instr;
	assign iq_id_ready = !instr_fifo_reject; // Output register frees when not rejected
	assign take        = iq_id_valid && iq_id_ready;
	assign funct7_ok   = (ins.r.funct7 == 7'b0000000) || (ins.r.funct7 == 7'b0100000);

	// Immediates of every format
	assign imm_i = {{52{ins.i.imm_11_0[11]}}, ins.i.imm_11_0};
	assign imm_s = {{52{ins.s.imm_11_5[6]}}, ins.s.imm_11_5, ins.s.imm_4_0};
	assign imm_b = {{51{ins.b.imm_12}}, ins.b.imm_12, ins.b.imm_11, ins.b.imm_10_5,
		ins.b.imm_4_1, 1'b0};
	assign imm_u = {{32{ins.u.imm_31_12[19]}}, ins.u.imm_31_12, 12'h000};
	assign imm_j = {{43{ins.j.imm_20}}, ins.j.imm_20, ins.j.imm_19_12, ins.j.imm_11,
		ins.j.imm_10_1, 1'b0};

	always_comb begin
		next_micro.pc              = iq_id.fb.pc;
		next_micro.funct3          = ins.r.funct3;
		next_micro.funct7_b5       = ins.r.funct7[5];
		next_micro.rd              = ins.r.rd;
		next_micro.rs1             = ins.r.rs1;
		next_micro.rs2             = ins.r.rs2;
		next_micro.predicted_taken = iq_id.predicted_taken;
		next_micro.op              = OP_ILLEGAL;
		next_micro.imm             = '0;
		case (ins.r.opcode)
			OPC_OP, OPC_OP_32: begin
				next_micro.op = funct7_ok ? OP_ALU : OP_ILLEGAL;
			end
			OPC_OP_IMM, OPC_OP_IMM_32: begin
				next_micro.op  = OP_ALU_IMM;
				next_micro.imm = imm_i;
			end
			OPC_LOAD: begin
				next_micro.op  = (ins.i.funct3 == 3'b111) ? OP_ILLEGAL : OP_LOAD; // No LDU
				next_micro.imm = imm_i;
			end
			OPC_STORE: begin
				next_micro.op  = ins.s.funct3[2] ? OP_ILLEGAL : OP_STORE; // SB to SD only
				next_micro.imm = imm_s;
			end
			OPC_BRANCH: begin
				next_micro.op  = (ins.b.funct3[2:1] == 2'b01) ? OP_ILLEGAL : OP_BRANCH;
				next_micro.imm = imm_b;
			end
			OPC_JAL: begin
				next_micro.op  = OP_JAL;
				next_micro.imm = imm_j;
			end
			OPC_JALR: begin
				next_micro.op  = (ins.i.funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
				next_micro.imm = imm_i;
			end
			OPC_LUI: begin
				next_micro.op  = OP_LUI;
				next_micro.imm = imm_u;
			end
			OPC_AUIPC: begin
				next_micro.op  = OP_AUIPC;
				next_micro.imm = imm_u;
			end
			OPC_SYSTEM, OPC_MISC_MEM: begin
				next_micro.op  = OP_SYSTEM; // CSR, ECALL and FENCE go to the back end
				next_micro.imm = imm_i;
			end
			default: next_micro.op = OP_ILLEGAL;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			instr_fifo_push <= 1'b0;
		end else if (flush) begin
			instr_fifo_push <= 1'b0; // Drop the wrong-path result
		end else if (!instr_fifo_reject) begin
			instr_fifo_push <= iq_id_valid;
		end
	end

	always_ff @(posedge CLK) begin
		if (take) begin
			decode_micro <= next_micro; // Held while rejected
		end
	end

endmodule

`default_nettype wire

/* rtl/front_end.sv */
`timescale 1ns/10ps
`default_nettype none

module front_end #(
	parameter logic [63:0] BOOT_PC  = 64'h0000_0000_8000_0000,
	parameter int          IQ_DEPTH = 4,
	parameter int          BR_DEPTH = 2
) (
	input  logic                         CLK,
	input  logic                         rst_n,
	input  logic                         instr_fifo_reject,
	output logic                         instr_fifo_push,
	output front_end_pkg::micro_instr_t  decode_micro,
	input  logic                         bru_res_valid,
	input  logic                         bru_taken_branch,
	input  logic                         jalr_valid,
	input  logic [63:0]                  jalr_pc,
	input  front_end_pkg::redirect_t     privileged,
	output logic                         ifu_req_valid,
	input  logic                         ifu_req_ready,
	output logic [63:0]                  ifu_addr,
	input  logic [63:0]                  ifu_data_r,
	input  logic                         ifu_rsp_valid,
	output logic                         flush
);
	import front_end_pkg::*;

	logic [63:0]   fetch_pc;
	logic          fetch_pc_ready;
	fetch_bundle_t if_iq;
	logic          if_iq_valid;
	logic          if_iq_ready;
	iq_bundle_t    iq_id;
	logic          iq_id_valid;
	logic          iq_id_ready;
	redirect_t     branch_redirect;
	redirect_t     mispredict;
	logic          kill;

	assign flush = mispredict.valid | privileged.valid; // Clears every stage
	assign kill  = flush | branch_redirect.valid;       // Fetch side only

	pc_generate #(
		.BOOT_PC(BOOT_PC)
	) u_pc_generate (
		.CLK            (CLK),
		.rst_n          (rst_n),
		.privileged     (privileged),
		.mispredict     (mispredict),
		.branch_redirect(branch_redirect),
		.fetch_pc_ready (fetch_pc_ready),
		.fetch_pc       (fetch_pc)
	);

	ifetch u_ifetch (
		.CLK           (CLK),
		.rst_n         (rst_n),
		.fetch_pc      (fetch_pc),
		.fetch_pc_ready(fetch_pc_ready),
		.ifu_req_valid (ifu_req_valid),
		.ifu_req_ready (ifu_req_ready),
		.ifu_addr      (ifu_addr),
		.ifu_data_r    (ifu_data_r),
		.ifu_rsp_valid (ifu_rsp_valid),
		.if_iq         (if_iq),
		.if_iq_valid   (if_iq_valid),
		.if_iq_ready   (if_iq_ready),
		.kill          (kill)
	);

	iqueue #(
		.IQ_DEPTH(IQ_DEPTH),
		.BR_DEPTH(BR_DEPTH)
	) u_iqueue (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.flush           (flush),
		.if_iq           (if_iq),
		.if_iq_valid     (if_iq_valid),
		.if_iq_ready     (if_iq_ready),
		.bru_res_valid   (bru_res_valid),
		.bru_taken_branch(bru_taken_branch),
		.jalr_valid      (jalr_valid),
		.jalr_pc         (jalr_pc),
		.branch_redirect (branch_redirect),
		.mispredict      (mispredict),
		.iq_id           (iq_id),
		.iq_id_valid     (iq_id_valid),
		.iq_id_ready     (iq_id_ready)
	);

	decoder u_decoder (
		.CLK              (CLK),
		.rst_n            (rst_n),
		.flush            (flush),
		.iq_id            (iq_id),
		.iq_id_valid      (iq_id_valid),
		.iq_id_ready      (iq_id_ready),
		.instr_fifo_reject(instr_fifo_reject),
		.instr_fifo_push  (instr_fifo_push),
		.decode_micro     (decode_micro)
	);

endmodule

`default_nettype wire

/* rtl/front_end_pkg.sv */
`default_nettype none

package front_end_pkg;

	// RV64I major opcodes
	localparam logic [6:0] OPC_LOAD      = 7'b0000011;
	localparam logic [6:0] OPC_MISC_MEM  = 7'b0001111; // FENCE
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011; // ADDIW and friends
	localparam logic [6:0] OPC_STORE     = 7'b0100011;
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011; // ADDW and friends
	localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
	localparam logic [6:0] OPC_JALR      = 7'b1100111;
	localparam logic [6:0] OPC_JAL       = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm_11_0;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12; // Sign bit, set for backward targets
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// One 32-bit word seen in every base format
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} instr_u;

	typedef struct packed {
		logic [63:0] pc;
		instr_u      instr;
	} fetch_bundle_t;

	// Queue head toward decode
	typedef struct packed {
		fetch_bundle_t fb;
		logic          predicted_taken;
	} iq_bundle_t;

	typedef struct packed {
		logic        valid;
		logic [63:0] pc;
	} redirect_t;

	typedef enum logic [3:0] {
		OP_ALU     = 4'd0,
		OP_ALU_IMM = 4'd1,
		OP_LOAD    = 4'd2,
		OP_STORE   = 4'd3,
		OP_BRANCH  = 4'd4,
		OP_JAL     = 4'd5,
		OP_JALR    = 4'd6,
		OP_LUI     = 4'd7,
		OP_AUIPC   = 4'd8,
		OP_SYSTEM  = 4'd9,
		OP_ILLEGAL = 4'd10
	} op_class_e;

	typedef struct packed {
		logic [63:0] pc;
		op_class_e   op;
		logic [2:0]  funct3;
		logic        funct7_b5; // SUB/SRA select
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [63:0] imm;       // Sign extended to XLEN
		logic        predicted_taken;
	} micro_instr_t;

endpackage

`default_nettype wire

/* rtl/ifetch.sv */
`timescale 1ns/10ps
`default_nettype none

module ifetch (
	input  logic                          CLK,
	input  logic                          rst_n,
	input  logic [63:0]                   fetch_pc,
	output logic                          fetch_pc_ready,
	output logic                          ifu_req_valid,
	input  logic                          ifu_req_ready,
	output logic [63:0]                   ifu_addr,
	input  logic [63:0]                   ifu_data_r,
	input  logic                          ifu_rsp_valid,
	output front_end_pkg::fetch_bundle_t  if_iq,
	output logic                          if_iq_valid,
	input  logic                          if_iq_ready,
	input  logic                          kill
);
	import front_end_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_WAIT,
		ST_HOLD
	} fetch_state_e;

	fetch_state_e state;
	logic         stale;      // Response in flight belongs to a killed path
	logic [63:0]  req_pc;     // PC of the request in flight
	instr_u       hold_instr; // Captured word for the queue

	// Take a new PC only when the queue has room and no redirect is landing
	assign fetch_pc_ready = (state == ST_IDLE) && if_iq_ready && !kill;
	assign ifu_req_valid  = (state == ST_REQ);
	assign ifu_addr       = {req_pc[63:3], 3'b000}; // Doubleword aligned
	assign if_iq_valid    = (state == ST_HOLD);
	assign if_iq.pc       = req_pc;
	assign if_iq.instr    = hold_instr;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			stale <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (fetch_pc_ready) begin
						state <= ST_REQ;
						stale <= 1'b0; // Fresh request
					end
				end
				ST_REQ: begin
					if (kill) begin
						stale <= 1'b1; // Keep requesting and drop the answer
					end
					if (ifu_req_ready) begin
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (kill) begin
						stale <= 1'b1;
					end
					if (ifu_rsp_valid) begin
						state <= (stale || kill) ? ST_IDLE : ST_HOLD; // Swallow stale data
					end
				end
				ST_HOLD: begin
					if (if_iq_ready || kill) begin
						state <= ST_IDLE; // Taken by iqueue or flushed away
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (fetch_pc_ready) begin
			req_pc <= fetch_pc;
		end
		if (state == ST_WAIT && ifu_rsp_valid) begin
			hold_instr <= req_pc[2] ? ifu_data_r[63:32] : ifu_data_r[31:0]; // Half select
		end
	end

endmodule

`default_nettype wire

/* rtl/iqueue.sv */
`timescale 1ns/10ps
`default_nettype none

module iqueue #(
	parameter int IQ_DEPTH = 4,
	parameter int BR_DEPTH = 2
) (
	input  logic                          CLK,
	input  logic                          rst_n,
	input  logic                          flush,
	input  front_end_pkg::fetch_bundle_t  if_iq,
	input  logic                          if_iq_valid,
	output logic                          if_iq_ready,
	input  logic                          bru_res_valid,
	input  logic                          bru_taken_branch,
	input  logic                          jalr_valid,
	input  logic [63:0]                   jalr_pc,
	output front_end_pkg::redirect_t      branch_redirect,
	output front_end_pkg::redirect_t      mispredict,
	output front_end_pkg::iq_bundle_t     iq_id,
	output logic                          iq_id_valid,
	input  logic                          iq_id_ready
);
	import front_end_pkg::*;

	localparam int IQ_AW = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
	localparam int BR_AW = (BR_DEPTH > 1) ? $clog2(BR_DEPTH) : 1;

	typedef struct packed {
		logic        pred;   // Direction that was guessed
		logic [63:0] alt_pc; // Path not taken by the guess
	} br_rec_t;

	instr_u                        in_word;
	logic                          is_branch;
	logic                          is_jal;
	logic                          is_jalr;
	logic                          pred_taken;
	logic [63:0]                   b_imm;
	logic [63:0]                   j_imm;
	logic                          wr_en;
	logic                          rd_en;
	logic                          br_push;
	logic                          br_pop;
	logic                          jalr_pend;
	iq_bundle_t                    iq_mem [IQ_DEPTH];
	logic [IQ_AW-1:0]              iq_wr_ptr;
	logic [IQ_AW-1:0]              iq_rd_ptr;
	logic [$clog2(IQ_DEPTH+1)-1:0] iq_count;
	br_rec_t                       br_mem [BR_DEPTH];
	logic [BR_AW-1:0]              br_wr_ptr;
	logic [BR_AW-1:0]              br_rd_ptr;
	logic [$clog2(BR_DEPTH+1)-1:0] br_count;

	assign in_word    = if_iq.instr;
	assign is_branch  = (in_word.b.opcode == OPC_BRANCH);
	assign is_jal     = (in_word.j.opcode == OPC_JAL);
	assign is_jalr    = (in_word.i.opcode == OPC_JALR);
	assign pred_taken = is_branch && in_word.b.imm_12; // Backward taken, forward not
	assign b_imm = {{51{in_word.b.imm_12}}, in_word.b.imm_12, in_word.b.imm_11,
		in_word.b.imm_10_5, in_word.b.imm_4_1, 1'b0};
	assign j_imm = {{43{in_word.j.imm_20}}, in_word.j.imm_20, in_word.j.imm_19_12,
		in_word.j.imm_11, in_word.j.imm_10_1, 1'b0};

	// Stall fetch on full queue, full branch record or pending JALR target
	assign if_iq_ready = (iq_count != IQ_DEPTH) && (br_count != BR_DEPTH) && !jalr_pend;
	assign wr_en       = if_iq_valid && if_iq_ready && !flush;
	assign br_push     = wr_en && is_branch;
	assign br_pop      = bru_res_valid && (br_count != 0); // Oldest branch resolves
	assign iq_id_valid = (iq_count != 0);
	assign iq_id       = iq_mem[iq_rd_ptr]; // Registered entry, one cycle minimum
	assign rd_en       = iq_id_valid && iq_id_ready;

	assign mispredict.valid = br_pop && (bru_taken_branch != br_mem[br_rd_ptr].pred);
	assign mispredict.pc    = br_mem[br_rd_ptr].alt_pc;

	always_comb begin
		branch_redirect.valid = wr_en && (is_jal || pred_taken); // Same cycle as the write
		branch_redirect.pc    = if_iq.pc + (is_jal ? j_imm : b_imm);
		if (jalr_pend && jalr_valid) begin
			branch_redirect.valid = 1'b1; // Back end hands over the target
			branch_redirect.pc    = jalr_pc;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			iq_wr_ptr <= '0;
			iq_rd_ptr <= '0;
			iq_count  <= '0;
			br_wr_ptr <= '0;
			br_rd_ptr <= '0;
			br_count  <= '0;
			jalr_pend <= 1'b0;
		end else begin
			if (wr_en) begin
				iq_wr_ptr <= (iq_wr_ptr == IQ_AW'(IQ_DEPTH - 1)) ? '0 : iq_wr_ptr + 1'b1;
			end
			if (rd_en) begin
				iq_rd_ptr <= (iq_rd_ptr == IQ_AW'(IQ_DEPTH - 1)) ? '0 : iq_rd_ptr + 1'b1;
			end
			if (wr_en && !rd_en) begin
				iq_count <= iq_count + 1'b1;
			end else if (!wr_en && rd_en) begin
				iq_count <= iq_count - 1'b1;
			end
			if (br_push) begin
				br_wr_ptr <= (br_wr_ptr == BR_AW'(BR_DEPTH - 1)) ? '0 : br_wr_ptr + 1'b1;
			end
			if (br_pop) begin
				br_rd_ptr <= (br_rd_ptr == BR_AW'(BR_DEPTH - 1)) ? '0 : br_rd_ptr + 1'b1;
			end
			if (br_push && !br_pop) begin
				br_count <= br_count + 1'b1;
			end else if (!br_push && br_pop) begin
				br_count <= br_count - 1'b1;
			end
			if (wr_en && is_jalr) begin
				jalr_pend <= 1'b1; // Hold writes until the target is known
			end else if (jalr_valid) begin
				jalr_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en) begin
			iq_mem[iq_wr_ptr].fb              <= if_iq;
			iq_mem[iq_wr_ptr].predicted_taken <= pred_taken;
		end
		if (br_push) begin
			br_mem[br_wr_ptr].pred   <= pred_taken;
			br_mem[br_wr_ptr].alt_pc <= pred_taken ? if_iq.pc + 64'd4 : if_iq.pc + b_imm;
		end
	end

endmodule

`default_nettype wire

/* rtl/pc_generate.sv */
`timescale 1ns/10ps
`default_nettype none

module pc_generate #(
	parameter logic [63:0] BOOT_PC = 64'h0000_0000_8000_0000
) (
	input  logic                      CLK,
	input  logic                      rst_n,
	input  front_end_pkg::redirect_t  privileged,
	input  front_end_pkg::redirect_t  mispredict,
	input  front_end_pkg::redirect_t  branch_redirect,
	input  logic                      fetch_pc_ready,
	output logic [63:0]               fetch_pc
);

	logic [63:0] seq_pc;

	assign seq_pc = fetch_pc + 64'd4; // Next word in program order

	// Redirects land one cycle after they are raised
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			fetch_pc <= BOOT_PC;
		end else if (privileged.valid) begin
			fetch_pc <= privileged.pc; // Trap or mret wins
		end else if (mispredict.valid) begin
			fetch_pc <= mispredict.pc; // Recorded alternate path
		end else if (branch_redirect.valid) begin
			fetch_pc <= branch_redirect.pc; // JAL, taken guess or JALR target
		end else if (fetch_pc_ready) begin
			fetch_pc <= seq_pc; // Advance only once ifetch took the PC
		end
	end

endmodule

`default_nettype wire

/* testbench/front_end_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module front_end_properties (
	input logic                        CLK,
	input logic                        rst_n,
	input logic                        ifu_req_valid,
	input logic                        ifu_req_ready,
	input logic                        instr_fifo_push,
	input logic                        instr_fifo_reject,
	input logic                        flush,
	input front_end_pkg::micro_instr_t decode_micro,
	input front_end_pkg::redirect_t    branch_redirect
);

	int prop_fail_cnt = 0; // Read by the testbench top

	// Bus request waits for ready
	assert property (@(posedge CLK) disable iff (!rst_n)
		ifu_req_valid && !ifu_req_ready |=> ifu_req_valid)
		else begin
			$error("ifu_req_valid dropped before ifu_req_ready");
			prop_fail_cnt++;
		end

	// Rejected micro-instruction holds
	assert property (@(posedge CLK) disable iff (!rst_n)
		instr_fifo_push && instr_fifo_reject && !flush |=> instr_fifo_push && $stable(decode_micro))
		else begin
			$error("decode_micro changed while rejected");
			prop_fail_cnt++;
		end

	assert property (@(posedge CLK) disable iff (!rst_n)
		flush |=> !instr_fifo_push)
		else begin
			$error("push in the cycle after flush");
			prop_fail_cnt++;
		end

	// Quiet outputs through reset
	assert property (@(posedge CLK)
		!rst_n |=> !ifu_req_valid && !instr_fifo_push && !flush && !branch_redirect.valid)
		else begin
			$error("output active during reset");
			prop_fail_cnt++;
		end

endmodule

bind front_end front_end_properties u_props (.*);

`default_nettype wire

/* testbench/tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 20, // 40 ns clock
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// Release on a falling edge, like every other DUT input
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* testbench/tb_front_end.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_front_end;
	import front_end_pkg::*;

	localparam logic [63:0] BOOT_PC    = 64'h0000_0000_8000_0000;
	localparam logic [63:0] HANDLER_PC = BOOT_PC + 64'd104; // Word 26
	localparam int          PROG_LEN   = 32;
	localparam int          N_PUSH     = 30;
	localparam int          TIMEOUT_CYCLES = 40 * N_PUSH + 200;
	localparam logic [31:0] SEED       = 32'h40f9_ff41;

	logic         clk;
	logic         rst_n;
	logic         instr_fifo_reject;
	logic         instr_fifo_push;
	micro_instr_t decode_micro;
	logic         bru_res_valid;
	logic         bru_taken_branch;
	logic         jalr_valid;
	logic [63:0]  jalr_pc;
	redirect_t    privileged;
	logic         ifu_req_valid;
	logic         ifu_req_ready;
	logic [63:0]  ifu_addr;
	logic [63:0]  ifu_data_r;
	logic         ifu_rsp_valid;
	logic         flush;

	logic [31:0]  prog [PROG_LEN];
	logic         outcomes [6] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0}; // Per dynamic branch
	micro_instr_t exp_q [$];
	micro_instr_t got_m;
	micro_instr_t exp_m;
	int           n_seen = 0;
	int           br_seen = 0;
	int           err_cnt = 0;
	int           to_cnt = 0;
	int           cycles = 0;
	logic         mem_busy;
	int           mem_wait;
	logic [63:0]  mem_addr;
	logic         res_pend = 1'b0; // Back-end actions for the next falling edge
	logic         res_taken;
	logic         res_mis;         // Injected outcome disagrees with the reference guess
	logic         jalr_pend_tb = 1'b0;
	logic [63:0]  jalr_tgt;
	logic         priv_pend = 1'b0;
	logic         flush_exp = 1'b0; // Flush due in the current cycle

	tb_clock_gen u_clock_gen (
		.clk  (clk),
		.rst_n(rst_n)
	);

	front_end #(
		.BOOT_PC (BOOT_PC),
		.IQ_DEPTH(4),
		.BR_DEPTH(2)
	) u_dut (
		.CLK              (clk),
		.rst_n            (rst_n),
		.instr_fifo_reject(instr_fifo_reject),
		.instr_fifo_push  (instr_fifo_push),
		.decode_micro     (decode_micro),
		.bru_res_valid    (bru_res_valid),
		.bru_taken_branch (bru_taken_branch),
		.jalr_valid       (jalr_valid),
		.jalr_pc          (jalr_pc),
		.privileged       (privileged),
		.ifu_req_valid    (ifu_req_valid),
		.ifu_req_ready    (ifu_req_ready),
		.ifu_addr         (ifu_addr),
		.ifu_data_r       (ifu_data_r),
		.ifu_rsp_valid    (ifu_rsp_valid),
		.flush            (flush)
	);

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
		input logic [6:0] opc);
		return {f7, rs2, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	// Memory word; outside the program an address-folded ADDI
	function automatic logic [31:0] word_at(input logic [63:0] a);
		logic [63:0] idx;
		logic [31:0] x;
		idx = (a - BOOT_PC) >> 2;
		x   = a[31:0] ^ a[63:32];
		if (a >= BOOT_PC && idx < PROG_LEN) begin
			return prog[idx];
		end
		return enc_i(x[11:0] ^ x[23:12] ^ {4'h0, x[31:24]}, 5'd0, 3'd0, 5'd0, OPC_OP_IMM);
	endfunction

	function automatic logic outcome_at(input int k);
		return (k < 6) ? outcomes[k] : 1'b0;
	endfunction

	// Back-end register model where rs1 of every JALR holds BOOT_PC
	function automatic logic [63:0] jalr_target(input logic [63:0] imm);
		logic [63:0] t;
		t = BOOT_PC + imm;
		return {t[63:1], 1'b0};
	endfunction

	// Reference decode straight from the RV64I formats
	function automatic micro_instr_t ref_decode(input logic [31:0] w, input logic [63:0] pc);
		micro_instr_t m;
		logic [63:0]  ii;
		logic [63:0]  is;
		logic [63:0]  ib;
		logic [63:0]  iu;
		logic [63:0]  ij;
		ii = {{52{w[31]}}, w[31:20]};
		is = {{52{w[31]}}, w[31:25], w[11:7]};
		ib = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		iu = {{32{w[31]}}, w[31:12], 12'h000};
		ij = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		m           = '0;
		m.pc        = pc;
		m.funct3    = w[14:12];
		m.funct7_b5 = w[30];
		m.rd        = w[11:7];
		m.rs1       = w[19:15];
		m.rs2       = w[24:20];
		m.op        = OP_ILLEGAL;
		m.predicted_taken = (w[6:0] == OPC_BRANCH) && w[31]; // Backward only
		case (w[6:0])
			OPC_OP, OPC_OP_32: begin
				if (w[31:25] == 7'h00 || w[31:25] == 7'h20) m.op = OP_ALU;
			end
			OPC_OP_IMM, OPC_OP_IMM_32: begin
				m.op  = OP_ALU_IMM;
				m.imm = ii;
			end
			OPC_LOAD: begin
				m.op  = (w[14:12] != 3'b111) ? OP_LOAD : OP_ILLEGAL;
				m.imm = ii;
			end
			OPC_STORE: begin
				m.op  = (w[14] == 1'b0) ? OP_STORE : OP_ILLEGAL;
				m.imm = is;
			end
			OPC_BRANCH: begin
				m.op  = (w[14:13] != 2'b01) ? OP_BRANCH : OP_ILLEGAL;
				m.imm = ib;
			end
			OPC_JAL: begin
				m.op  = OP_JAL;
				m.imm = ij;
			end
			OPC_JALR: begin
				m.op  = (w[14:12] == 3'b000) ? OP_JALR : OP_ILLEGAL;
				m.imm = ii;
			end
			OPC_LUI, OPC_AUIPC: begin
				m.op  = (w[6:0] == OPC_LUI) ? OP_LUI : OP_AUIPC;
				m.imm = iu;
			end
			OPC_SYSTEM, OPC_MISC_MEM: begin
				m.op  = OP_SYSTEM;
				m.imm = ii;
			end
			default: m.op = OP_ILLEGAL;
		endcase
		return m;
	endfunction

	task automatic load_program();
		for (int k = 0; k < PROG_LEN; k++) begin
			prog[k] = enc_i(12'(k), 5'd0, 3'd0, 5'd0, OPC_OP_IMM); // Filler seen only on wrong paths
		end
		prog[0]  = enc_i(12'd5, 5'd0, 3'd0, 5'd1, OPC_OP_IMM);
		prog[1]  = enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2, OPC_OP);
		prog[2]  = enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd3, OPC_OP); // SUB
		prog[3]  = enc_i(12'd16, 5'd1, 3'd3, 5'd4, OPC_LOAD);
		prog[4]  = enc_s(12'hFF8, 5'd4, 5'd2, 3'd3);
		prog[5]  = {20'h12345, 5'd5, OPC_LUI};
		prog[6]  = {20'hFFFFF, 5'd6, OPC_AUIPC};
		prog[7]  = enc_i(12'hFFF, 5'd1, 3'd0, 5'd7, OPC_OP_IMM_32);
		prog[8]  = enc_b(13'd12, 5'd2, 5'd1, 3'd0);   // Forward to 11
		prog[9]  = enc_i(12'd1, 5'd8, 3'd0, 5'd8, OPC_OP_IMM);
		prog[10] = enc_b(13'h1FFC, 5'd0, 5'd8, 3'd1); // Backward to 9
		prog[11] = enc_b(13'd8, 5'd2, 5'd1, 3'd4);    // Forward to 13 and resolves taken
		prog[13] = enc_j(21'd12, 5'd1);               // To 16
		prog[16] = enc_i(12'd80, 5'd1, 3'd0, 5'd0, OPC_JALR); // Target word 20
		prog[20] = 32'hFFFF_FFFF;
		prog[21] = 32'h0000_0000;
		prog[22] = enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd9, OPC_OP); // MUL is illegal without M
		prog[23] = 32'h0000_0073; // ECALL
		prog[26] = enc_i(12'd4, 5'd0, 3'd2, 5'd10, OPC_LOAD);
		prog[27] = enc_b(13'h1FFC, 5'd2, 5'd1, 3'd5); // Backward to 26
		prog[28] = enc_j(21'd0, 5'd0);                // Spin here
	endtask

	// Reference predictor walk with the injected outcomes
	task automatic build_expected();
		logic [63:0]  pc;
		logic [31:0]  w;
		micro_instr_t m;
		int           k;
		pc = BOOT_PC;
		k  = 0;
		for (int n = 0; n < N_PUSH; n++) begin
			w = word_at(pc);
			m = ref_decode(w, pc);
			exp_q.push_back(m);
			if (w[6:0] == OPC_BRANCH) begin
				pc = outcome_at(k) ? pc + m.imm : pc + 64'd4;
				k++;
			end else if (w[6:0] == OPC_JAL) begin
				pc = pc + m.imm;
			end else if (w[6:0] == OPC_JALR) begin
				pc = jalr_target(m.imm);
			end else if (w == 32'h0000_0073) begin
				pc = HANDLER_PC;
			end else begin
				pc = pc + 64'd4;
			end
		end
	endtask

	always @(posedge clk) begin
		cycles++;
	end

	// Fetch memory answers after 1 to 4 cycles
	always @(negedge clk) begin
		if (!rst_n) begin
			mem_busy      = 1'b0;
			ifu_rsp_valid = 1'b0;
			ifu_req_ready = 1'b0;
		end else begin
			ifu_rsp_valid = 1'b0;
			if (mem_busy) begin
				if (mem_wait == 0) begin
					ifu_rsp_valid = 1'b1;
					ifu_data_r    = {word_at(mem_addr + 64'd4), word_at(mem_addr)};
					mem_busy      = 1'b0;
				end else begin
					mem_wait--;
				end
			end
			ifu_req_ready = !mem_busy && ($urandom_range(0, 3) != 0);
			if (ifu_req_valid && ifu_req_ready) begin // Handshake at the next rising edge
				mem_busy = 1'b1;
				mem_addr = ifu_addr;
				mem_wait = $urandom_range(0, 3);
			end
		end
	end

	// Back-end drive
	always @(negedge clk) begin
		bru_res_valid = 1'b0;
		jalr_valid    = 1'b0;
		privileged    = '0;
		flush_exp     = 1'b0;
		if (res_pend) begin
			bru_res_valid    = 1'b1;
			bru_taken_branch = res_taken;
			flush_exp        = res_mis;
			res_pend         = 1'b0;
		end
		if (jalr_pend_tb) begin
			jalr_valid   = 1'b1;
			jalr_pc      = jalr_tgt;
			jalr_pend_tb = 1'b0;
		end
		if (priv_pend) begin
			privileged.valid = 1'b1; // ECALL traps to the handler
			privileged.pc    = HANDLER_PC;
			flush_exp        = 1'b1;
			priv_pend        = 1'b0;
		end
		instr_fifo_reject = rst_n && ($urandom_range(0, 99) < 30);
	end

	// Compare accepted pushes; a push under flush is younger and dies
	always @(posedge clk) begin
		if (rst_n) begin
			assert (flush == flush_exp) else begin
				err_cnt++;
				$display("[FAIL] %0t ns: flush %b, exp %b", $time, flush, flush_exp);
			end
		end
		if (rst_n && instr_fifo_push && !instr_fifo_reject && !flush) begin
			got_m = decode_micro;
			if (n_seen < N_PUSH) begin
				exp_m = exp_q[n_seen];
				assert (got_m == exp_m) else begin
					err_cnt++;
					$display("[FAIL] %0t ns: push %0d got pc %h op %0d imm %h pt %b",
						$time, n_seen, got_m.pc, got_m.op, got_m.imm, got_m.predicted_taken);
					$display("[FAIL] %0t ns: push %0d exp pc %h op %0d imm %h pt %b",
						$time, n_seen, exp_m.pc, exp_m.op, exp_m.imm, exp_m.predicted_taken);
				end
			end
			n_seen++;
			if (got_m.op == OP_BRANCH) begin
				res_pend  = 1'b1;
				res_taken = outcome_at(br_seen);
				res_mis   = (res_taken != exp_m.predicted_taken);
				br_seen++;
			end
			if (got_m.op == OP_JALR) begin
				jalr_pend_tb = 1'b1;
				jalr_tgt     = jalr_target(got_m.imm);
			end
			if (got_m.op == OP_SYSTEM && got_m.imm == 64'd0 && got_m.funct3 == 3'd0) begin
				priv_pend = 1'b1;
			end
		end
	end

	initial begin
		void'($urandom(SEED));
		instr_fifo_reject = 1'b0;
		bru_res_valid     = 1'b0;
		bru_taken_branch  = 1'b0;
		jalr_valid        = 1'b0;
		jalr_pc           = '0;
		privileged        = '0;
		ifu_req_ready     = 1'b0;
		ifu_data_r        = '0;
		ifu_rsp_valid     = 1'b0;
		load_program();
		build_expected();
		wait (rst_n);
		while (n_seen < N_PUSH && cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
		end
		assert (n_seen >= N_PUSH) else begin
			to_cnt++;
			$display("Timeout: %0d cycles passed with only %0d of %0d pushes seen",
				cycles, n_seen, N_PUSH);
		end
		$display("Errors: %0d value mismatches, %0d property failures, %0d timeouts",
			err_cnt, u_dut.u_props.prop_fail_cnt, to_cnt);
		if (err_cnt == 0 && to_cnt == 0 && u_dut.u_props.prop_fail_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
